// File: hdl/camCfgPkg.sv
package camCfgPkg;

	// Register table layout
	localparam logic [7:0] TABLE_LEN = 8'd171;
	localparam logic [7:0] CFG_BASE = 8'd2; // First write entry after MIDH/MIDL
	localparam string TABLE_FILE = "ov7670Rgb565.hex";
	localparam logic [7:0] CAM_ID_WR = 8'h42;
	localparam logic [7:0] CAM_ID_RD = 8'h43;

	localparam logic [15:0] SCCB_HALF = 16'd16; // Clocks per half SIOC period

	// APB register map
	localparam logic [3:0] REG_CTRL = 4'h0;
	localparam logic [3:0] REG_STATUS = 4'h4;
	localparam logic [3:0] REG_ID = 4'h8;
	localparam logic [3:0] REG_PROGRESS = 4'hC;

	typedef struct packed {
		logic [7:0] regAddr;
		logic [7:0] data;
		logic isRead;
	} sccbReq_t;

	typedef struct packed {
		logic [7:0] regAddr;
		logic [7:0] value; // Expected ID byte for the read entries
	} cfgEntry_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [3:0] paddr;
		logic [31:0] pwdata;
	} apbReq_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apbRsp_t;

	typedef struct packed {
		logic busy;
		logic done;
		logic idOk;
		logic idFail;
		logic [7:0] progress;
	} cfgStatus_t;

endpackage

// File: hdl/ov7670RegRom.sv
`timescale 1ns/1ps

module ov7670RegRom import camCfgPkg::*;
(
	input logic clk,
	input logic [7:0] romIndex,
	output cfgEntry_t entry
);

	cfgEntry_t mem [0:TABLE_LEN-1];

	// Address/value pairs, RGB565 VGA setup
	initial
	begin
		$readmemh(TABLE_FILE, mem);
	end

	always_ff @(posedge clk)
	begin
		if (romIndex < TABLE_LEN)
			entry <= mem[romIndex];
		else
			entry <= '0; // Past the end of the table
	end

endmodule

// File: hdl/cfgSequencer.sv
`timescale 1ns/1ps

module cfgSequencer import camCfgPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic start,
	output logic [7:0] romIndex,
	input cfgEntry_t entry,
	output sccbReq_t req,
	output logic reqValid,
	input logic reqReady,
	input logic rspValid,
	input logic [7:0] rdData,
	output cfgStatus_t status,
	output logic [15:0] idBytes
);

	typedef enum logic [1:0] {S_IDLE, S_FETCH, S_ISSUE, S_WAIT} seqState_t;

	seqState_t state;
	logic isIdEntry;
	logic idMismatch;
	logic lastEntry;

	assign isIdEntry = romIndex < CFG_BASE;
	assign idMismatch = isIdEntry && (rdData != entry.value);
	assign lastEntry = romIndex == (TABLE_LEN - 8'd1);

	// Entry stays stable while waiting, so req is taken straight from the ROM
	assign req = '{regAddr: entry.regAddr, data: entry.value, isRead: isIdEntry};
	assign reqValid = state == S_ISSUE;

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= S_IDLE;
			romIndex <= '0;
			status <= '0;
			idBytes <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					if (start) // Start while busy never gets here
					begin
						romIndex <= '0;
						status <= '{busy: 1'b1, done: 1'b0, idOk: 1'b0, idFail: 1'b0,
							progress: 8'd0};
						state <= S_FETCH;
					end
				end
				S_FETCH:
					state <= S_ISSUE; // ROM read cycle
				S_ISSUE:
				begin
					if (reqReady)
						state <= S_WAIT;
				end
				S_WAIT:
				begin
					if (rspValid)
					begin
						status.progress <= status.progress + 8'd1;
						if (isIdEntry && romIndex == 8'd0)
							idBytes[15:8] <= rdData; // MIDH
						else if (isIdEntry)
							idBytes[7:0] <= rdData; // MIDL
						if (idMismatch)
						begin
							status.idFail <= 1'b1; // Abort before any write
							status.done <= 1'b1;
							status.busy <= 1'b0;
							state <= S_IDLE;
						end
						else
						begin
							if (isIdEntry && romIndex == CFG_BASE - 8'd1)
								status.idOk <= 1'b1;
							if (lastEntry)
							begin
								status.done <= 1'b1;
								status.busy <= 1'b0;
								state <= S_IDLE;
							end
							else
							begin
								romIndex <= romIndex + 8'd1;
								state <= S_FETCH;
							end
						end
					end
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: hdl/sccbMaster.sv
`timescale 1ns/1ps

module sccbMaster import camCfgPkg::*;
(
	input logic clk,
	input logic rstN,
	input sccbReq_t req,
	input logic reqValid,
	output logic reqReady,
	output logic rspValid,
	output logic [7:0] rdData,
	output logic sioc,
	output logic siodOe,
	input logic siodIn
);

	typedef enum logic [1:0] {PH_START, PH_BYTE, PH_STOP} phase_t;

	sccbReq_t reqLat;
	logic active;
	logic [15:0] divCnt;
	logic [4:0] halfCnt; // Half SIOC periods within the current step
	logic [2:0] step;
	logic siocQ;
	logic sdaRel; // 1 releases SIOD
	logic [7:0] rxShift;

	phase_t phase;
	logic [7:0] txByte;
	logic [3:0] bitIdx;
	logic bitVal;
	logic lastHalf;
	logic lastStep;
	logic rxStep;
	logic siocNext;
	logic sdaNext;
	logic halfEnd;
	logic midHalf;
	logic xferEnd;

	// Write: start, ID, addr, data, stop
	// Read: start, ID, addr, stop, start, ID+1, rx byte, stop
	always_comb
	begin
		phase = PH_BYTE;
		txByte = 8'hFF; // Released, also for the receive byte
		if (reqLat.isRead)
		begin
			case (step)
				3'd0, 3'd4: phase = PH_START;
				3'd3, 3'd7: phase = PH_STOP;
				3'd1: txByte = CAM_ID_WR;
				3'd2: txByte = reqLat.regAddr;
				3'd5: txByte = CAM_ID_RD;
				default: txByte = 8'hFF;
			endcase
		end
		else
		begin
			case (step)
				3'd0: phase = PH_START;
				3'd1: txByte = CAM_ID_WR;
				3'd2: txByte = reqLat.regAddr;
				3'd3: txByte = reqLat.data;
				default: phase = PH_STOP;
			endcase
		end
	end

	assign bitIdx = halfCnt[4:1];
	assign bitVal = bitIdx[3] ? 1'b1 : txByte[3'd7 - bitIdx[2:0]]; // Ninth bit released
	assign lastHalf = (phase == PH_BYTE) ? (halfCnt == 5'd17) : (halfCnt == 5'd3);
	assign lastStep = step == (reqLat.isRead ? 3'd7 : 3'd4);
	assign rxStep = reqLat.isRead && (step == 3'd6);
	assign halfEnd = divCnt == SCCB_HALF - 16'd1;
	assign midHalf = divCnt == SCCB_HALF / 16'd2;
	assign xferEnd = active && halfEnd && lastHalf && lastStep;

	always_comb
	begin
		case (phase)
			PH_START:
			begin
				siocNext = halfCnt != 5'd3;
				sdaNext = !halfCnt[1]; // SIOD falls with SIOC high
			end
			PH_STOP:
			begin
				siocNext = halfCnt != 5'd0;
				sdaNext = halfCnt[1]; // SIOD rises with SIOC high
			end
			default:
			begin
				siocNext = halfCnt[0];
				sdaNext = bitVal;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			active <= 1'b0;
			divCnt <= '0;
			halfCnt <= '0;
			step <= '0;
			siocQ <= 1'b1;
			sdaRel <= 1'b1;
			rspValid <= 1'b0;
		end
		else
		begin
			rspValid <= 1'b0;
			if (!active)
			begin
				if (reqValid)
				begin
					active <= 1'b1;
					divCnt <= '0;
					halfCnt <= '0;
					step <= '0;
				end
			end
			else
			begin
				if (divCnt == 16'd0)
					siocQ <= siocNext;
				if (midHalf)
					sdaRel <= sdaNext; // Data moves mid low half
				if (halfEnd)
				begin
					divCnt <= '0;
					if (lastHalf)
					begin
						halfCnt <= '0;
						if (lastStep)
						begin
							active <= 1'b0;
							rspValid <= 1'b1;
						end
						else
							step <= step + 3'd1;
					end
					else
						halfCnt <= halfCnt + 5'd1;
				end
				else
					divCnt <= divCnt + 16'd1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reqValid && reqReady)
			reqLat <= req;
		if (active && rxStep && halfCnt[0] && !bitIdx[3] && midHalf)
			rxShift <= {rxShift[6:0], siodIn}; // MSB first, SIOC high
		if (xferEnd)
			rdData <= rxShift;
	end

	assign reqReady = !active;
	assign sioc = siocQ;
	assign siodOe = !sdaRel;

endmodule

// File: hdl/camCfgApbRegs.sv
`timescale 1ns/1ps

module camCfgApbRegs import camCfgPkg::*;
(
	input logic clk,
	input logic rstN,
	input apbReq_t apbReq,
	output apbRsp_t apbRsp,
	output logic start,
	input cfgStatus_t status,
	input logic [15:0] idBytes
);

	logic setupPhase;
	logic accessPhase;
	logic mapped;
	logic wrCtrl;
	logic slvErr;
	logic [31:0] rdMux;
	logic [31:0] prdataQ;

	assign setupPhase = apbReq.psel && !apbReq.penable;
	assign accessPhase = apbReq.psel && apbReq.penable;
	assign mapped = apbReq.paddr inside {REG_CTRL, REG_STATUS, REG_ID, REG_PROGRESS};
	assign wrCtrl = accessPhase && apbReq.pwrite && (apbReq.paddr == REG_CTRL);
	// Only CTRL is writable
	assign slvErr = accessPhase &&
		(!mapped || (apbReq.pwrite && apbReq.paddr != REG_CTRL));

	always_comb
	begin
		case (apbReq.paddr)
			REG_STATUS:
				rdMux = {28'd0, status.idFail, status.idOk, status.done, status.busy};
			REG_ID:
				rdMux = {16'd0, idBytes}; // MIDH in the upper byte
			REG_PROGRESS:
				rdMux = {24'd0, status.progress};
			default:
				rdMux = 32'd0; // CTRL and unmapped read as zero
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			start <= 1'b0;
			prdataQ <= '0;
		end
		else
		begin
			start <= wrCtrl && apbReq.pwdata[0]; // One-cycle pulse
			if (setupPhase && !apbReq.pwrite)
				prdataQ <= rdMux; // Ready for the access phase
		end
	end

	assign apbRsp = '{prdata: prdataQ, pready: 1'b1, pslverr: slvErr};

endmodule

// File: hdl/camCfgTop.sv
`timescale 1ns/1ps

module camCfgTop import camCfgPkg::*;
(
	input logic clk,
	input logic rstN,
	input apbReq_t apbReq,
	output apbRsp_t apbRsp,
	output logic sioc,
	output logic siodOe,
	input logic siodIn
);

	logic start;
	cfgStatus_t status;
	logic [15:0] idBytes;
	logic [7:0] romIndex;
	cfgEntry_t entry;
	sccbReq_t req;
	logic reqValid;
	logic reqReady;
	logic rspValid;
	logic [7:0] rdData;

	camCfgApbRegs uApbRegs (.clk(clk), .rstN(rstN), .apbReq(apbReq), .apbRsp(apbRsp),
		.start(start), .status(status), .idBytes(idBytes));

	cfgSequencer uSequencer (.clk(clk), .rstN(rstN), .start(start), .romIndex(romIndex),
		.entry(entry), .req(req), .reqValid(reqValid), .reqReady(reqReady),
		.rspValid(rspValid), .rdData(rdData), .status(status), .idBytes(idBytes));

	ov7670RegRom uRom (.clk(clk), .romIndex(romIndex), .entry(entry));

	sccbMaster uSccb (.clk(clk), .rstN(rstN), .req(req), .reqValid(reqValid),
		.reqReady(reqReady), .rspValid(rspValid), .rdData(rdData), .sioc(sioc),
		.siodOe(siodOe), .siodIn(siodIn));

endmodule

// File: tests/camCfgAssertions.sv
`timescale 1ns/1ps

module camCfgAssertions import camCfgPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic sioc,
	input logic siodOe,
	input logic inByte,
	input sccbReq_t req,
	input logic reqValid,
	input logic reqReady,
	input apbReq_t apbReq,
	input apbRsp_t apbRsp
);

	// Data bits move only while SIOC is low, start and stop excluded
	assert property (@(posedge clk) disable iff (!rstN)
		inByte && sioc && $past(sioc) |-> $stable(siodOe))
		else $error("SIOD changed while SIOC was high inside a byte");

	assert property (@(posedge clk) disable iff (!rstN)
		reqValid && !reqReady |=> reqValid && $stable(req))
		else $error("Bus request dropped or changed before it was accepted");

	// Every setup phase is followed by an access phase that completes at once
	assert property (@(posedge clk) disable iff (!rstN)
		apbReq.psel && !apbReq.penable |=> apbReq.psel && apbReq.penable && apbRsp.pready)
		else $error("APB setup phase not followed by a ready access phase");

endmodule

// APB side tied off here
bind sccbMaster camCfgAssertions uSccbChecks (.clk(clk), .rstN(rstN), .sioc(sioc),
	.siodOe(siodOe), .inByte(phase == PH_BYTE), .req(req), .reqValid(reqValid),
	.reqReady(reqReady), .apbReq('0), .apbRsp('0));

// SCCB side tied off here
bind camCfgApbRegs camCfgAssertions uApbChecks (.clk(clk), .rstN(rstN), .sioc(1'b0),
	.siodOe(1'b0), .inByte(1'b0), .req('0), .reqValid(1'b0), .reqReady(1'b1),
	.apbReq(apbReq), .apbRsp(apbRsp));

// File: tests/tbClkGen.sv
`timescale 1ns/1ps

module tbClkGen
(
	output logic clk,
	output logic rstN
);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk; // 8 ns period
	end

	initial
	begin
		rstN <= 1'b0;
		repeat (2) @(posedge clk);
		rstN <= 1'b1;
	end

endmodule

// File: tests/camCfgTb.sv
`timescale 1ns/1ps

module camCfgTb import camCfgPkg::*;
();

	logic clk;
	logic rstN;
	apbReq_t apbReq;
	apbRsp_t apbRsp;
	logic sioc;
	logic siodOe;
	logic siodIn;

	logic [15:0] refTable [0:TABLE_LEN-1]; // Expected table, same file as the ROM
	logic [7:0] camRegs [0:255]; // Sensor register file
	logic [15:0] wrLog [$]; // Writes seen on the bus as {addr, data}

	logic camPull = 1'b0;
	logic siocQ = 1'b1;
	logic siodQ = 1'b1;
	logic [7:0] rxByte = 8'd0;
	logic [3:0] bitCnt = 4'd0;
	logic [1:0] byteCnt = 2'd0;
	logic rdMode = 1'b0;
	logic [7:0] regPtr = 8'd0;
	logic txOn = 1'b0;
	logic [3:0] txBit = 4'd0;
	logic [7:0] txByte = 8'd0;

	tbClkGen uClkGen (.clk(clk), .rstN(rstN));

	camCfgTop u_dut (.clk(clk), .rstN(rstN), .apbReq(apbReq), .apbRsp(apbRsp), .sioc(sioc),
		.siodOe(siodOe), .siodIn(siodIn));

	assign siodIn = !siodOe && !camPull; // Open drain, either side pulls low

	task automatic failNow(input string msg);
		$display("FAIL at %0d ns: %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	// Camera side of SCCB, oversampled on clk
	always @(posedge clk)
	begin
		siocQ <= sioc;
		siodQ <= siodIn;
		if (sioc && siocQ && siodQ && !siodIn)
		begin
			bitCnt <= 4'd0; // Start condition
			byteCnt <= 2'd0;
			txOn <= 1'b0;
		end
		else if (sioc && siocQ && !siodQ && siodIn)
		begin
			txOn <= 1'b0; // Stop condition
			camPull <= 1'b0;
		end
		else if (sioc && !siocQ)
		begin
			if (bitCnt == 4'd8)
			begin
				bitCnt <= 4'd0; // Don't-care bit ends the byte
				byteCnt <= byteCnt + 2'd1;
				if (byteCnt == 2'd0)
				begin
					assert (rxByte == 8'h42 || rxByte == 8'h43)
					else failNow($sformatf("bad SCCB device address 0x%h", rxByte));
					rdMode <= rxByte == 8'h43;
					if (rxByte == 8'h43)
					begin
						txOn <= 1'b1;
						txBit <= 4'd0;
						txByte <= camRegs[regPtr];
					end
				end
				else if (!rdMode && byteCnt == 2'd1)
					regPtr <= rxByte;
				else if (!rdMode && byteCnt == 2'd2)
					wrLog.push_back({regPtr, rxByte});
			end
			else
			begin
				rxByte <= {rxByte[6:0], siodIn};
				bitCnt <= bitCnt + 4'd1;
			end
		end
		else if (!sioc && siocQ && txOn)
		begin
			if (txBit < 4'd8)
			begin
				camPull <= !txByte[3'd7 - txBit[2:0]]; // MSB first
				txBit <= txBit + 4'd1;
			end
			else
			begin
				camPull <= 1'b0; // Master drives NA
				txOn <= 1'b0;
			end
		end
	end

	task automatic idleCycles(input int unsigned maxGap);
		repeat ($urandom_range(maxGap)) @(posedge clk);
	endtask

	task automatic apbAccess(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(posedge clk);
		apbReq <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(posedge clk);
		apbReq.penable <= 1'b1;
		@(negedge clk);
		rdata = apbRsp.prdata;
		err = apbRsp.pslverr;
		assert (apbRsp.pready) else failNow("pready low in the APB access phase");
		@(posedge clk);
		apbReq <= '0;
	endtask

	task automatic regRead(input logic [3:0] addr, output logic [31:0] data);
		logic err;
		idleCycles(3);
		apbAccess(1'b0, addr, 32'd0, data, err);
		assert (!err) else failNow($sformatf("pslverr on a read of 0x%h", addr));
	endtask

	task automatic expectReg(input logic [3:0] addr, input logic [31:0] expected);
		logic [31:0] data;
		regRead(addr, data);
		assert (data == expected)
		else failNow($sformatf("reg 0x%h read 0x%h, expected 0x%h", addr, data, expected));
	endtask

	task automatic startRun();
		logic [31:0] rdIgnored;
		logic err;
		idleCycles(3);
		apbAccess(1'b1, REG_CTRL, 32'd1, rdIgnored, err);
		assert (!err) else failNow("pslverr on a CTRL write");
	endtask

	// Poll STATUS until done, PROGRESS at random in between
	task automatic runPoll(input logic pokeBusy);
		logic [31:0] st;
		logic [31:0] prog;
		logic [7:0] lastProg;
		logic poked;
		lastProg = 8'd0;
		poked = 1'b0;
		do
		begin
			idleCycles(200);
			if ($urandom_range(1) == 1)
			begin
				regRead(REG_PROGRESS, prog);
				assert (prog[7:0] >= lastProg)
				else failNow($sformatf("PROGRESS fell from %0d to %0d", lastProg, prog[7:0]));
				lastProg = prog[7:0];
				if (pokeBusy && !poked && lastProg >= 8'd16)
				begin
					startRun(); // Sequencer is busy here
					poked = 1'b1;
				end
			end
			regRead(REG_STATUS, st);
			assert (st[0] != st[1]) else failNow($sformatf("STATUS 0x%h busy equals done", st));
		end
		while (!st[1]);
		assert (poked || !pokeBusy) else failNow("no start was written during the busy run");
	endtask

	initial
	begin
		longint limitNs;
		// Table length x 40 bit times x 2 half periods x 8 ns x 3 runs
		limitNs = longint'(TABLE_LEN) * 40 * 2 * longint'(SCCB_HALF) * 8 * 3 + 200000;
		#(limitNs);
		$display("Timeout: the configuration runs did not finish within %0d ns", limitNs);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		logic [31:0] rd;
		logic err;
		logic wr;
		logic [3:0] badAddr;
		logic [7:0] newMidl;
		int logBase;
		int i;
		apbReq <= '0;
		void'($urandom(32'h3afc_58a7));
		$readmemh(TABLE_FILE, refTable);
		for (i = 0; i < 256; i++)
			camRegs[i] = 8'(i) ^ 8'h5A;
		camRegs[8'h1C] = 8'h7F; // MIDH
		camRegs[8'h1D] = 8'hA2; // MIDL
		wait (rstN);
		@(negedge clk);
		assert (sioc === 1'b1 && siodOe === 1'b0) else failNow("SCCB lines not idle after reset");
		expectReg(REG_STATUS, 32'd0);
		expectReg(REG_PROGRESS, 32'd0);
		expectReg(REG_ID, 32'd0);
		expectReg(REG_CTRL, 32'd0);

		repeat (8)
		begin
			if ($urandom_range(1) == 0)
			begin
				do
					badAddr = 4'($urandom);
				while (badAddr[1:0] == 2'b00);
				wr = 1'($urandom);
			end
			else
			begin
				badAddr = {2'($urandom_range(3, 1)), 2'b00}; // Read-only register
				wr = 1'b1;
			end
			idleCycles(3);
			apbAccess(wr, badAddr, $urandom, rd, err);
			assert (err) else failNow($sformatf("no pslverr for wr=%0b at 0x%h", wr, badAddr));
		end
		expectReg(REG_STATUS, 32'd0);

		logBase = wrLog.size();
		startRun();
		runPoll(1'b1);
		assert (wrLog.size() - logBase == int'(TABLE_LEN) - int'(CFG_BASE))
		else failNow($sformatf("%0d writes logged", wrLog.size() - logBase));
		for (i = 0; i < int'(TABLE_LEN) - int'(CFG_BASE); i++)
			assert (wrLog[logBase + i] == refTable[int'(CFG_BASE) + i])
			else failNow($sformatf("write %0d is %h, expected %h", i, wrLog[logBase + i],
				refTable[int'(CFG_BASE) + i]));
		expectReg(REG_STATUS, 32'h6); // done and idOk
		expectReg(REG_ID, 32'h0000_7FA2);
		expectReg(REG_PROGRESS, {24'd0, TABLE_LEN});

		do
			newMidl = 8'($urandom);
		while (newMidl == 8'hA2);
		camRegs[8'h1D] = newMidl;
		logBase = wrLog.size();
		startRun();
		runPoll(1'b0);
		expectReg(REG_STATUS, 32'hA); // done and idFail
		assert (wrLog.size() == logBase)
		else failNow($sformatf("%0d writes after an ID mismatch", wrLog.size() - logBase));
		expectReg(REG_ID, {16'd0, 8'h7F, newMidl});
		expectReg(REG_PROGRESS, 32'd2); // Both ID reads completed

		$display("TEST PASSED");
		$finish;
	end

endmodule

// File: ov7670Rgb565.hex
// Each word holds the register address in the high byte and the value in the low byte
// Words 0 and 1 are the MIDH and MIDL reads and hold the expected ID byte
1C7F 1DA2 1280 1204 1100 0C00 3E00 8C00
0400 40D0 3A04 1438 4FB3 50B3 5100 523D
53A7 54E4 5840 3DC0 1711 1861 3203 19C3
1A7B 030A 0E61 0F4B 1602 1E07 2102 2291
2907 330B 350B 371D 3871 392A 3C78 4D40
4E20 6900 6B4A 7410 8D4F 8E00 8F00 9000
9100 9600 9A00 B084 B10C B20E B382 B80A
7A20 7B10 7C1E 7D35 7E5A 7F69 8076 8180
8288 838F 8496 85A3 86AF 87C4 88D7 89E8
13E0 0000 1000 0D40 1418 A505 AB07 2495
2533 26E3 9F78 A068 A103 A6D8 A7D8 A8F0
A990 AA94 13E5 0E61 0F4B 1602 1E07 2102
2291 2907 330B 350B 371D 3871 392A 3C78
4D40 4E20 6900 6B4A 7410 8D4F 8E00 8F00
9000 9100 9600 9A00 B084 B10C B20E B382
430A 44F0 4534 4658 4728 483A 5988 5A88
5B44 5C67 5D49 5E0E 6C0A 6D55 6E11 6F9F
6A40 0140 0260 13E7 4F80 5080 5100 5222
535E 5480 589E 4108 3F00 7505 76E1 4C00
7701 3DC3 4B09 C960 4138 5640 3411 3B12
A488 9600 9730 9820 9930 9A84 9B29 9C03
9D4C 9E3F 7804

// File: all.f
hdl/camCfgPkg.sv
hdl/ov7670RegRom.sv
hdl/cfgSequencer.sv
hdl/sccbMaster.sv
hdl/camCfgApbRegs.sv
hdl/camCfgTop.sv
tests/camCfgAssertions.sv
tests/tbClkGen.sv
tests/camCfgTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the camera configuration testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module camCfgTb \
	--Mdir obj_dir -o camCfgSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/camCfgSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulator exited with status $simStatus"
fi

if grep -q "^TEST PASSED$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
